// ==== design/dbg_pkg.sv ====
package dbg_pkg;

  localparam int NUM_PE  = 3;
  localparam int NUM_CNT = 11;

  typedef logic [19:0]       bus_addr_t;
  typedef logic [31:0]       bus_data_t;
  typedef logic [31:0]       cnt_t;
  typedef logic [3:0]        region_t;
  typedef logic [2:0]        offset_t;
  typedef logic [5:0]        reg_id_t;
  typedef logic [8:0]        pe_irq_t;
  typedef logic [3:0]        ready_t;
  typedef logic [3:0]        state_nib_t;
  typedef logic [6:0]        usedw7_t;
  typedef logic [29:0]       usedw30_t;
  typedef logic [NUM_PE-1:0] pe_vec_t;

  localparam region_t REGION_IRQ  = 4'd6;
  localparam region_t REGION_PKT  = 4'd7;
  localparam region_t REGION_DMA  = 4'd8;
  localparam region_t REGION_CORE = 4'd10;

  // counter indices, NUM_CNT-1 is the unused slot
  localparam logic [3:0] CNT_RX_TOTAL = 4'd0;
  localparam logic [3:0] CNT_RX_DMA   = 4'd1;
  localparam logic [3:0] CNT_RX_DRA   = 4'd2;
  localparam logic [3:0] CNT_RX_CONF  = 4'd3;
  localparam logic [3:0] CNT_MUX_DRA  = 4'd4;
  localparam logic [3:0] CNT_MUX_DMA  = 4'd5;
  localparam logic [3:0] CNT_MUX_CONF = 4'd6;
  localparam logic [3:0] CNT_DIST_PE0 = 4'd7;
  localparam logic [3:0] CNT_DIST_PE1 = 4'd8;
  localparam logic [3:0] CNT_DIST_PE2 = 4'd9;

  typedef enum logic [1:0] {
    IDLE,
    PROBE_WAIT,
    RESP_ACK,
    WAIT_END
  } bus_state_e;

endpackage

// ==== design/pkt_event_counters.sv ====
`timescale 1ns/10ps

module pkt_event_counters (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  dbg_pkg::ready_t  i_rx_inc,
  input  logic             i_mux_inc_dra,
  input  logic             i_mux_inc_dma,
  input  logic             i_mux_inc_conf,
  input  dbg_pkg::pe_vec_t i_dist_inc,
  input  logic [3:0]       i_sel,
  output dbg_pkg::cnt_t    o_count
);

  localparam int NUM_LIVE = dbg_pkg::NUM_CNT - 1;

  dbg_pkg::cnt_t         cnt_q [NUM_LIVE];
  logic [NUM_LIVE-1:0]   inc;

  // flag order follows the counter index scheme
  assign inc = {i_dist_inc, i_mux_inc_conf, i_mux_inc_dma, i_mux_inc_dra, i_rx_inc};

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_LIVE; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_LIVE; i++) begin
        if (inc[i]) begin
          // free running, wraps at 2^32
          cnt_q[i] <= cnt_q[i] + dbg_pkg::cnt_t'(1);
        end
      end
    end
  end

  always_comb begin
    o_count = '0;
    if (int'(i_sel) < NUM_LIVE) begin
      o_count = cnt_q[i_sel];
    end
  end

endmodule

// ==== design/core_probe.sv ====
`timescale 1ns/10ps

module core_probe #(
  parameter int PROBE_SETTLE_CYCLES = 2
) (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_start,
  input  dbg_pkg::reg_id_t   i_reg_id,
  input  dbg_pkg::offset_t   i_offset,
  input  dbg_pkg::bus_data_t i_pe_reg_value0,
  input  dbg_pkg::bus_data_t i_pe_reg_value1,
  input  dbg_pkg::bus_data_t i_pe_reg_value2,
  input  dbg_pkg::bus_data_t i_pc0,
  input  dbg_pkg::bus_data_t i_pc1,
  input  dbg_pkg::bus_data_t i_pc2,
  output dbg_pkg::reg_id_t   o_pe_reg_id0,
  output dbg_pkg::reg_id_t   o_pe_reg_id1,
  output dbg_pkg::reg_id_t   o_pe_reg_id2,
  output logic               o_done,
  output dbg_pkg::bus_data_t o_value
);

  localparam int SETTLE_W = $clog2(PROBE_SETTLE_CYCLES + 1);

  logic                busy_q;
  logic [SETTLE_W-1:0] settle_q;
  logic                settle_done;
  dbg_pkg::offset_t    offset_q;
  dbg_pkg::bus_data_t  value_sel;

  assign settle_done = busy_q && (settle_q == SETTLE_W'(PROBE_SETTLE_CYCLES - 1));

  always_comb begin
    case (offset_q)
      3'd0:    value_sel = i_pe_reg_value0;
      3'd1:    value_sel = i_pe_reg_value1;
      3'd2:    value_sel = i_pe_reg_value2;
      3'd4:    value_sel = i_pc0;
      3'd5:    value_sel = i_pc1;
      3'd6:    value_sel = i_pc2;
      default: value_sel = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pe_reg_id0 <= '0;
      o_pe_reg_id1 <= '0;
      o_pe_reg_id2 <= '0;
      offset_q     <= '0;
      busy_q       <= 1'b0;
      settle_q     <= '0;
      o_done       <= 1'b0;
    end else begin
      o_done <= settle_done;
      if (i_start) begin
        // same id goes to every core
        o_pe_reg_id0 <= i_reg_id;
        o_pe_reg_id1 <= i_reg_id;
        o_pe_reg_id2 <= i_reg_id;
        offset_q     <= i_offset;
        busy_q       <= 1'b1;
        settle_q     <= '0;
      end else if (settle_done) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        settle_q <= settle_q + SETTLE_W'(1);
      end
    end
  end

  // sampled together with the done pulse
  always_ff @(posedge i_clk) begin
    if (settle_done) begin
      o_value <= value_sel;
    end
  end

endmodule

// ==== design/dbg_read_mux.sv ====
`timescale 1ns/10ps

module dbg_read_mux (
  input  dbg_pkg::region_t    i_region,
  input  dbg_pkg::offset_t    i_offset,
  input  dbg_pkg::cnt_t       i_count,
  output logic [3:0]          o_cnt_sel,
  output dbg_pkg::bus_data_t  o_word,
  input  dbg_pkg::ready_t     i_peri_ready,
  input  dbg_pkg::pe_irq_t    i_pe_irq0,
  input  dbg_pkg::pe_irq_t    i_pe_irq1,
  input  dbg_pkg::pe_irq_t    i_pe_irq2,
  input  dbg_pkg::state_nib_t i_mux_state,
  input  dbg_pkg::usedw7_t    i_usedw_dma,
  input  dbg_pkg::usedw7_t    i_usedw_dra,
  input  dbg_pkg::usedw7_t    i_usedw_conf,
  input  logic                i_dist_state,
  input  dbg_pkg::state_nib_t i_out_state,
  input  dbg_pkg::pe_vec_t    i_dma_alf,
  input  dbg_pkg::usedw30_t   i_usedw_dmawr,
  input  dbg_pkg::usedw30_t   i_usedw_pbufrd
);

  // counter lookup, unused slot reads zero
  always_comb begin
    o_cnt_sel = 4'(dbg_pkg::NUM_CNT - 1);
    if (i_region == dbg_pkg::REGION_PKT) begin
      case (i_offset)
        3'd0: o_cnt_sel = dbg_pkg::CNT_RX_TOTAL;
        3'd1: o_cnt_sel = dbg_pkg::CNT_RX_DMA;
        3'd2: o_cnt_sel = dbg_pkg::CNT_RX_DRA;
        3'd3: o_cnt_sel = dbg_pkg::CNT_RX_CONF;
        3'd4: o_cnt_sel = dbg_pkg::CNT_MUX_DRA;
        3'd5: o_cnt_sel = dbg_pkg::CNT_MUX_DMA;
        3'd7: o_cnt_sel = dbg_pkg::CNT_MUX_CONF;
        default: ;
      endcase
    end else if (i_region == dbg_pkg::REGION_DMA) begin
      case (i_offset)
        3'd0: o_cnt_sel = dbg_pkg::CNT_DIST_PE0;
        3'd1: o_cnt_sel = dbg_pkg::CNT_DIST_PE1;
        3'd2: o_cnt_sel = dbg_pkg::CNT_DIST_PE2;
        default: ;
      endcase
    end
  end

  always_comb begin
    o_word = '0;
    case (i_region)
      dbg_pkg::REGION_IRQ: o_word = {1'b0, i_peri_ready, i_pe_irq0, i_pe_irq1, i_pe_irq2};
      dbg_pkg::REGION_PKT: begin
        if (i_offset == 3'd6) begin
          o_word = {4'b0, i_mux_state, 1'b0, i_usedw_dma,
                    1'b0, i_usedw_dra, 1'b0, i_usedw_conf};
        end else begin
          o_word = i_count;
        end
      end
      dbg_pkg::REGION_DMA: begin
        case (i_offset)
          3'd0, 3'd1, 3'd2: o_word = i_count;
          3'd3: o_word = {8'b0, 7'b0, i_dist_state, 4'b0, i_out_state, 5'b0, i_dma_alf};
          3'd6: o_word = {2'b0, i_usedw_dmawr};
          3'd7: o_word = {2'b0, i_usedw_pbufrd};
          default: o_word = '0;
        endcase
      end
      default: o_word = '0;
    endcase
  end

endmodule

// ==== design/localbus_slave.sv ====
`timescale 1ns/10ps

module localbus_slave #(
  parameter int PROBE_SETTLE_CYCLES = 2
) (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_cs,
  input  logic               i_wr_rd,
  input  dbg_pkg::bus_addr_t i_addr,
  input  dbg_pkg::bus_data_t i_word,
  input  logic               i_probe_done,
  input  dbg_pkg::bus_data_t i_probe_value,
  output dbg_pkg::region_t   o_region,
  output dbg_pkg::offset_t   o_offset,
  output dbg_pkg::reg_id_t   o_reg_id,
  output logic               o_probe_start,
  output logic               o_ack_n,
  output dbg_pkg::bus_data_t o_rdata
);

  // probe normally answers after PROBE_SETTLE_CYCLES+1 edges in PROBE_WAIT
  localparam int WAIT_LIMIT = PROBE_SETTLE_CYCLES + 1;
  localparam int WAIT_W     = $clog2(WAIT_LIMIT + 1);

  dbg_pkg::bus_state_e state_q;
  logic [WAIT_W-1:0]   wait_q;

  assign o_region = i_addr[19:16];
  assign o_offset = i_addr[2:0];
  assign o_reg_id = i_addr[13:8];

  // writes never move the core ids
  assign o_probe_start = (state_q == dbg_pkg::IDLE) && !i_cs && !i_wr_rd &&
                         (o_region == dbg_pkg::REGION_CORE);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= dbg_pkg::IDLE;
      wait_q  <= '0;
      o_ack_n <= 1'b1;
      o_rdata <= '0;
    end else begin
      case (state_q)
        dbg_pkg::IDLE: begin
          if (!i_cs) begin
            if (o_probe_start) begin
              wait_q  <= '0;
              state_q <= dbg_pkg::PROBE_WAIT;
            end else begin
              o_rdata <= i_word;
              state_q <= dbg_pkg::RESP_ACK;
            end
          end
        end
        dbg_pkg::PROBE_WAIT: begin
          if (i_probe_done) begin
            o_rdata <= i_probe_value;
            state_q <= dbg_pkg::RESP_ACK;
          end else if (wait_q == WAIT_W'(WAIT_LIMIT)) begin
            // lost probe, answer zero rather than hang the bus
            o_rdata <= '0;
            state_q <= dbg_pkg::RESP_ACK;
          end else begin
            wait_q <= wait_q + WAIT_W'(1);
          end
        end
        dbg_pkg::RESP_ACK: begin
          o_ack_n <= 1'b0;
          state_q <= dbg_pkg::WAIT_END;
        end
        dbg_pkg::WAIT_END: begin
          // hold ack and data until the master lets go
          if (i_cs) begin
            o_ack_n <= 1'b1;
            state_q <= dbg_pkg::IDLE;
          end
        end
        default: state_q <= dbg_pkg::IDLE;
      endcase
    end
  end

endmodule

// ==== design/pe_debug_top.sv ====
`timescale 1ns/10ps

module pe_debug_top #(
  parameter int PROBE_SETTLE_CYCLES = 2
) (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_cs,
  input  logic                i_wr_rd,
  input  dbg_pkg::bus_addr_t  i_addr,
  output logic                o_ack_n,
  output dbg_pkg::bus_data_t  o_rdata,
  input  dbg_pkg::ready_t     i_rx_inc,
  input  logic                i_mux_inc_dra,
  input  logic                i_mux_inc_dma,
  input  logic                i_mux_inc_conf,
  input  dbg_pkg::pe_vec_t    i_dist_inc,
  input  dbg_pkg::ready_t     i_peri_ready,
  input  dbg_pkg::pe_irq_t    i_pe_irq0,
  input  dbg_pkg::pe_irq_t    i_pe_irq1,
  input  dbg_pkg::pe_irq_t    i_pe_irq2,
  input  dbg_pkg::state_nib_t i_mux_state,
  input  dbg_pkg::usedw7_t    i_usedw_dma,
  input  dbg_pkg::usedw7_t    i_usedw_dra,
  input  dbg_pkg::usedw7_t    i_usedw_conf,
  input  logic                i_dist_state,
  input  dbg_pkg::state_nib_t i_out_state,
  input  dbg_pkg::pe_vec_t    i_dma_alf,
  input  dbg_pkg::usedw30_t   i_usedw_dmawr,
  input  dbg_pkg::usedw30_t   i_usedw_pbufrd,
  input  dbg_pkg::bus_data_t  i_pe_reg_value0,
  input  dbg_pkg::bus_data_t  i_pe_reg_value1,
  input  dbg_pkg::bus_data_t  i_pe_reg_value2,
  input  dbg_pkg::bus_data_t  i_pc0,
  input  dbg_pkg::bus_data_t  i_pc1,
  input  dbg_pkg::bus_data_t  i_pc2,
  output dbg_pkg::reg_id_t    o_pe_reg_id0,
  output dbg_pkg::reg_id_t    o_pe_reg_id1,
  output dbg_pkg::reg_id_t    o_pe_reg_id2
);

  dbg_pkg::region_t   region;
  dbg_pkg::offset_t   offset;
  dbg_pkg::reg_id_t   reg_id;
  dbg_pkg::bus_data_t word;
  dbg_pkg::bus_data_t probe_value;
  dbg_pkg::cnt_t      count;
  logic [3:0]         cnt_sel;
  logic               probe_start;
  logic               probe_done;

  localbus_slave #(
    .PROBE_SETTLE_CYCLES(PROBE_SETTLE_CYCLES)
  ) u_localbus_slave (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_cs(i_cs),
    .i_wr_rd(i_wr_rd),
    .i_addr(i_addr),
    .i_word(word),
    .i_probe_done(probe_done),
    .i_probe_value(probe_value),
    .o_region(region),
    .o_offset(offset),
    .o_reg_id(reg_id),
    .o_probe_start(probe_start),
    .o_ack_n(o_ack_n),
    .o_rdata(o_rdata)
  );

  dbg_read_mux u_dbg_read_mux (
    .i_region(region),
    .i_offset(offset),
    .i_count(count),
    .o_cnt_sel(cnt_sel),
    .o_word(word),
    .i_peri_ready(i_peri_ready),
    .i_pe_irq0(i_pe_irq0),
    .i_pe_irq1(i_pe_irq1),
    .i_pe_irq2(i_pe_irq2),
    .i_mux_state(i_mux_state),
    .i_usedw_dma(i_usedw_dma),
    .i_usedw_dra(i_usedw_dra),
    .i_usedw_conf(i_usedw_conf),
    .i_dist_state(i_dist_state),
    .i_out_state(i_out_state),
    .i_dma_alf(i_dma_alf),
    .i_usedw_dmawr(i_usedw_dmawr),
    .i_usedw_pbufrd(i_usedw_pbufrd)
  );

  pkt_event_counters u_pkt_event_counters (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_rx_inc(i_rx_inc),
    .i_mux_inc_dra(i_mux_inc_dra),
    .i_mux_inc_dma(i_mux_inc_dma),
    .i_mux_inc_conf(i_mux_inc_conf),
    .i_dist_inc(i_dist_inc),
    .i_sel(cnt_sel),
    .o_count(count)
  );

  core_probe #(
    .PROBE_SETTLE_CYCLES(PROBE_SETTLE_CYCLES)
  ) u_core_probe (
    .i_clk(i_clk),
    .i_rst_n(i_rst_n),
    .i_start(probe_start),
    .i_reg_id(reg_id),
    .i_offset(offset),
    .i_pe_reg_value0(i_pe_reg_value0),
    .i_pe_reg_value1(i_pe_reg_value1),
    .i_pe_reg_value2(i_pe_reg_value2),
    .i_pc0(i_pc0),
    .i_pc1(i_pc1),
    .i_pc2(i_pc2),
    .o_pe_reg_id0(o_pe_reg_id0),
    .o_pe_reg_id1(o_pe_reg_id1),
    .o_pe_reg_id2(o_pe_reg_id2),
    .o_done(probe_done),
    .o_value(probe_value)
  );

endmodule

// ==== tests/pe_debug_checker.sv ====
`timescale 1ns/10ps

module pe_debug_checker (
  input logic                i_clk,
  input logic                i_rst_n,
  input logic                i_cs,
  input logic                i_ack_n,
  input dbg_pkg::bus_state_e i_state
);

  int idle_fail_cnt    = 0;
  int fall_fail_cnt    = 0;
  int release_fail_cnt = 0;

  // no acknowledge while nothing is pending
  ack_idle_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_state == dbg_pkg::IDLE) |-> i_ack_n)
    else begin
      idle_fail_cnt++;
      $error("ack low while the bus FSM is idle");
    end

  ack_fall_with_cs: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $fell(i_ack_n) |-> !$past(i_cs))
    else begin
      fall_fail_cnt++;
      $error("ack fell without a pending request");
    end

  // release seen in WAIT_END clears ack on the next edge
  ack_release: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_state == dbg_pkg::WAIT_END && i_cs) |=> i_ack_n)
    else begin
      release_fail_cnt++;
      $error("ack still low one edge after cs release");
    end

endmodule

bind localbus_slave pe_debug_checker u_bus_checker (
  .i_clk(i_clk),
  .i_rst_n(i_rst_n),
  .i_cs(i_cs),
  .i_ack_n(o_ack_n),
  .i_state(state_q)
);

// ==== tests/pe_debug_tb.sv ====
`timescale 1ns/10ps

module pe_debug_tb;

  localparam int PROBE_SETTLE = 2;
  localparam int WAIT_LIMIT   = 50;

  logic                i_clk;
  logic                i_rst_n;
  logic                i_cs;
  logic                i_wr_rd;
  dbg_pkg::bus_addr_t  i_addr;
  logic                o_ack_n;
  dbg_pkg::bus_data_t  o_rdata;
  dbg_pkg::ready_t     i_rx_inc;
  logic                i_mux_inc_dra;
  logic                i_mux_inc_dma;
  logic                i_mux_inc_conf;
  dbg_pkg::pe_vec_t    i_dist_inc;
  dbg_pkg::ready_t     i_peri_ready;
  dbg_pkg::pe_irq_t    i_pe_irq0;
  dbg_pkg::pe_irq_t    i_pe_irq1;
  dbg_pkg::pe_irq_t    i_pe_irq2;
  dbg_pkg::state_nib_t i_mux_state;
  dbg_pkg::usedw7_t    i_usedw_dma;
  dbg_pkg::usedw7_t    i_usedw_dra;
  dbg_pkg::usedw7_t    i_usedw_conf;
  logic                i_dist_state;
  dbg_pkg::state_nib_t i_out_state;
  dbg_pkg::pe_vec_t    i_dma_alf;
  dbg_pkg::usedw30_t   i_usedw_dmawr;
  dbg_pkg::usedw30_t   i_usedw_pbufrd;
  dbg_pkg::bus_data_t  i_pe_reg_value0;
  dbg_pkg::bus_data_t  i_pe_reg_value1;
  dbg_pkg::bus_data_t  i_pe_reg_value2;
  dbg_pkg::bus_data_t  i_pc0;
  dbg_pkg::bus_data_t  i_pc1;
  dbg_pkg::bus_data_t  i_pc2;
  dbg_pkg::reg_id_t    o_pe_reg_id0;
  dbg_pkg::reg_id_t    o_pe_reg_id1;
  dbg_pkg::reg_id_t    o_pe_reg_id2;

  // one flag per counter index 0 to 9
  logic [9:0]          ev_flags;
  int                  n_fail;
  int                  n_other;
  int                  n_assert;
  int                  n_reads;
  dbg_pkg::reg_id_t    last_id;

  assign {i_dist_inc, i_mux_inc_conf, i_mux_inc_dma, i_mux_inc_dra, i_rx_inc} = ev_flags;

  pe_debug_top #(
    .PROBE_SETTLE_CYCLES(PROBE_SETTLE)
  ) dut0 (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic check_word(input string name, input dbg_pkg::bus_data_t exp,
                            input dbg_pkg::bus_data_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      n_fail++;
    end
  endtask

  task automatic check_count(input string name, input dbg_pkg::cnt_t exp,
                             input dbg_pkg::cnt_t act);
    if (act !== exp) begin
      $display("Fail %s: expected count %0d, actual %0d", name, exp, act);
      n_fail++;
    end
  endtask

  task automatic check_reg_id(input string name, input dbg_pkg::reg_id_t exp,
                              input dbg_pkg::reg_id_t act);
    if (act !== exp) begin
      $display("Fail %s: expected id %h, actual %h", name, exp, act);
      n_fail++;
    end
  endtask

  task automatic check_edges(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Fail %s: expected %0d edges, actual %0d", name, exp, act);
      n_fail++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      n_fail++;
    end
  endtask

  task automatic pulse_event(input int ch, input int count);
    if (count > 0) begin
      @(posedge i_clk);
      #1;
      ev_flags = 10'b1 << ch;
      // flag stays high for exactly count sampling edges
      repeat (count) @(posedge i_clk);
      #1;
      ev_flags = '0;
    end
  endtask

  task automatic set_input(input string field, input logic [31:0] v);
    @(posedge i_clk);
    #1;
    case (field)
      "ready": i_peri_ready    = v[3:0];
      "irq0":  i_pe_irq0       = v[8:0];
      "irq1":  i_pe_irq1       = v[8:0];
      "irq2":  i_pe_irq2       = v[8:0];
      "mux":   i_mux_state     = v[3:0];
      "udma":  i_usedw_dma     = v[6:0];
      "udra":  i_usedw_dra     = v[6:0];
      "uconf": i_usedw_conf    = v[6:0];
      "dist":  i_dist_state    = v[0];
      "out":   i_out_state     = v[3:0];
      "alf":   i_dma_alf       = v[2:0];
      "dmawr": i_usedw_dmawr   = v[29:0];
      "pbuf":  i_usedw_pbufrd  = v[29:0];
      "val0":  i_pe_reg_value0 = v;
      "val1":  i_pe_reg_value1 = v;
      "val2":  i_pe_reg_value2 = v;
      "pc0":   i_pc0           = v;
      "pc1":   i_pc1           = v;
      "pc2":   i_pc2           = v;
      default: begin
        $display("unknown input field %s in golden file", field);
        n_other++;
      end
    endcase
  endtask

  task automatic bus_access(input string name, input dbg_pkg::bus_addr_t addr,
                            input logic wr, output dbg_pkg::bus_data_t data);
    int gap;
    int edges;
    int exp_edges;
    gap = int'($urandom % 4);
    while (gap > 0) begin
      @(posedge i_clk);
      gap--;
    end
    @(posedge i_clk);
    #1;
    i_addr  = addr;
    i_wr_rd = wr;
    i_cs    = 1'b0;
    edges   = 0;
    while (o_ack_n && edges < WAIT_LIMIT) begin
      @(posedge i_clk);
      #1;
      edges++;
    end
    data = o_rdata;
    if (o_ack_n) begin
      $display("no acknowledge for %s within %0d cycles", name, WAIT_LIMIT);
      n_other++;
    end else begin
      // probe reads add the settle time and the value capture edge
      exp_edges = (!wr && addr[19:16] == dbg_pkg::REGION_CORE) ? PROBE_SETTLE + 3 : 2;
      check_edges({name, " ack latency"}, exp_edges, edges);
    end
    i_cs  = 1'b1;
    edges = 0;
    while (!o_ack_n && edges < WAIT_LIMIT) begin
      @(posedge i_clk);
      #1;
      edges++;
    end
    if (!o_ack_n) begin
      $display("ack of %s stayed low after cs release", name);
      n_other++;
    end else begin
      check_edges({name, " ack release"}, 1, edges);
    end
    if (!wr && addr[19:16] == dbg_pkg::REGION_CORE) begin
      last_id = addr[13:8];
    end
    check_reg_id({name, " id0"}, last_id, o_pe_reg_id0);
    check_reg_id({name, " id1"}, last_id, o_pe_reg_id1);
    check_reg_id({name, " id2"}, last_id, o_pe_reg_id2);
  endtask

  task automatic run_golden();
    int                 fd;
    int                 n;
    logic [8*24-1:0]    word_v;
    logic [8*128-1:0]   rest;
    string              kind;
    string              name;
    logic [31:0]        a;
    logic [31:0]        v;
    dbg_pkg::bus_data_t data;
    fd = $fopen("tests/pe_debug_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/pe_debug_golden.txt");
      n_other++;
      return;
    end
    while ($fscanf(fd, "%s", word_v) == 1) begin
      kind = string'(word_v);
      case (kind)
        "#": n = $fgets(rest, fd);
        "ev": begin
          n = $fscanf(fd, "%d %d", a, v);
          pulse_event(int'(a), int'(v));
        end
        "st", "core": begin
          n = $fscanf(fd, "%s %h", word_v, v);
          set_input(string'(word_v), v);
        end
        "rd", "cnt": begin
          n = $fscanf(fd, "%s %h %h", word_v, a, v);
          name = string'(word_v);
          bus_access(name, a[19:0], 1'b0, data);
          if (kind == "cnt") begin
            check_count(name, v, data);
          end else begin
            check_word(name, v, data);
          end
          n_reads++;
        end
        "wr": begin
          n = $fscanf(fd, "%s %h", word_v, a);
          bus_access(string'(word_v), a[19:0], 1'b1, data);
        end
        default: begin
          $display("unknown record kind %s in golden file", kind);
          n_other++;
          n = $fgets(rest, fd);
        end
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    int unsigned seed_val;
    seed_val        = $urandom(32'h61a0);
    n_fail          = 0;
    n_other         = 0;
    n_assert        = 0;
    n_reads         = 0;
    last_id         = '0;
    i_rst_n         = 1'b0;
    i_cs            = 1'b1;
    i_wr_rd         = 1'b0;
    i_addr          = '0;
    ev_flags        = '0;
    i_peri_ready    = '0;
    i_pe_irq0       = '0;
    i_pe_irq1       = '0;
    i_pe_irq2       = '0;
    i_mux_state     = '0;
    i_usedw_dma     = '0;
    i_usedw_dra     = '0;
    i_usedw_conf    = '0;
    i_dist_state    = 1'b0;
    i_out_state     = '0;
    i_dma_alf       = '0;
    i_usedw_dmawr   = '0;
    i_usedw_pbufrd  = '0;
    i_pe_reg_value0 = '0;
    i_pe_reg_value1 = '0;
    i_pe_reg_value2 = '0;
    i_pc0           = '0;
    i_pc1           = '0;
    i_pc2           = '0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    check_flag("reset ack", 1'b1, o_ack_n);
    check_word("reset rdata", '0, o_rdata);
    check_reg_id("reset id0", '0, o_pe_reg_id0);
    check_reg_id("reset id1", '0, o_pe_reg_id1);
    check_reg_id("reset id2", '0, o_pe_reg_id2);
    run_golden();
    if (n_reads == 0) begin
      $display("golden file held no reads");
      n_other++;
    end
    n_assert = dut0.u_localbus_slave.u_bus_checker.idle_fail_cnt
             + dut0.u_localbus_slave.u_bus_checker.fall_fail_cnt
             + dut0.u_localbus_slave.u_bus_checker.release_fail_cnt;
    $display("errors: %0d mismatches, %0d other, %0d assertion failures",
             n_fail, n_other, n_assert);
    if (n_fail == 0 && n_other == 0 && n_assert == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== tests/pe_debug_golden.txt ====
# ev <counter index> <pulses> | st <field> <hex> | core <field> <hex>
# rd/cnt <name> <hex addr> <hex expected> | wr <name> <hex addr>
cnt cnt_zero_after_reset 70000 0
ev 0 7
ev 1 3
ev 2 12
ev 3 1
ev 4 5
ev 5 9
ev 6 4
ev 7 2
ev 8 6
ev 9 10
ev 0 3
cnt rx_total 70000 a
cnt rx_dma 70001 3
cnt rx_dra 70002 c
cnt rx_conf 70003 1
cnt mux_dra 70004 5
cnt mux_dma 70005 9
cnt mux_conf 70007 4
cnt dist_pe0 80000 2
cnt dist_pe1 80001 6
cnt dist_pe2 80002 a
st ready a
st irq0 1a5
st irq1 0c3
st irq2 15a
st mux 9
st udma 55
st udra 2a
st uconf 7f
st dist 1
st out c
st alf 5
st dmawr 2f0f0f0f
st pbuf 15a5a5a5
rd irq_word 60000 5695875a
rd mux_status 70006 09552a7f
rd dma_status 80003 00010c05
rd dmawr_fill 80006 2f0f0f0f
rd pbuf_fill 80007 15a5a5a5
core val0 11110000
core val1 22220001
core val2 33330002
core pc0 0000a000
core pc1 0000b004
core pc2 0000c008
rd probe_val0 a0500 11110000
rd probe_pc1 a2a05 0000b004
rd probe_val2 a3f02 33330002
rd probe_pc2 a0106 0000c008
rd probe_off3 a0703 0
rd probe_off7 a0907 0
rd region0 00000 0
rd region1 10001 0
rd region2 20002 0
rd region3 30003 0
rd region4 40004 0
rd region5 50005 0
rd region9 90000 0
rd dma_off4 80004 0
rd dma_off5 80005 0
wr wr_rx_total 70000
wr wr_dist_pe1 80001
wr wr_probe a1500
cnt rx_total_after_wr 70000 a
cnt dist_pe1_after_wr 80001 6

// ==== pe_debug.f ====
design/dbg_pkg.sv
design/pkt_event_counters.sv
design/core_probe.sv
design/dbg_read_mux.sv
design/localbus_slave.sv
design/pe_debug_top.sv
tests/pe_debug_checker.sv
tests/pe_debug_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the pe_debug testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f pe_debug.f --top-module pe_debug_tb -o pe_debug_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/pe_debug_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
